// File: bin2bcd.sv
`timescale 1ns/10ps

module bin2bcd import reaction_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  logic [VAL_W-1:0] i_bin,
    output logic [15:0]      o_bcd,
    output logic             o_done,
    output logic             o_busy
);

    logic [15:0]      bcd_sr;
    logic [15:0]      bcd_adj;
    logic [VAL_W-1:0] bin_sr;
    logic [4:0]       bit_cnt;  // Shifts still to do

    // Add 3 to every digit of 5 or more before the shift
    always_comb begin
        bcd_adj = bcd_sr;
        for (int k = 0; k < 4; k++) begin
            if (bcd_sr[4*k +: 4] >= 4'd5) begin
                bcd_adj[4*k +: 4] = bcd_sr[4*k +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start && !o_busy) begin
            bin_sr <= i_bin;
            bcd_sr <= 16'd0;
        end else if (o_busy) begin
            bcd_sr <= {bcd_adj[14:0], bin_sr[VAL_W-1]};  // MSB first
            bin_sr <= {bin_sr[VAL_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_busy  <= 1'b0;
            o_done  <= 1'b0;
            bit_cnt <= 5'd0;
        end else begin
            o_done <= 1'b0;
            if (i_start && !o_busy) begin
                o_busy  <= 1'b1;
                bit_cnt <= 5'(VAL_W);
            end else if (o_busy) begin
                bit_cnt <= bit_cnt - 5'd1;
                if (bit_cnt == 5'd1) begin
                    o_busy <= 1'b0;
                    o_done <= 1'b1;  // Same edge as the last shift
                end
            end
        end
    end

    assign o_bcd = bcd_sr;  // Held until the next start

endmodule

// File: debouncer.sv
`timescale 1ns/10ps

module debouncer import reaction_pkg::*; (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_tick,
    input  logic i_sw,
    output logic o_sw_debounced
);

    logic [1:0] sync;        // Two-flop synchronizer
    logic [7:0] stable_cnt;  // Ticks the new level has held

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sync           <= 2'b00;
            stable_cnt     <= 8'd0;
            o_sw_debounced <= 1'b0;
        end else begin
            sync <= {sync[0], i_sw};

            if (sync[1] == o_sw_debounced) begin
                stable_cnt <= 8'd0;  // Bounce back, start over
            end else if (i_tick) begin
                if (stable_cnt == DB_TICKS - 8'd1) begin
                    o_sw_debounced <= sync[1];
                    stable_cnt     <= 8'd0;
                end else begin
                    stable_cnt <= stable_cnt + 8'd1;
                end
            end
        end
    end

endmodule

// File: list.f
reaction_pkg.sv
tick_gen.sv
debouncer.sv
reaction.sv
bin2bcd.sv
sseg4.sv
reaction_top.sv
tb_clock.sv
reaction_properties.sv
tb_reaction.sv

// File: reaction.sv
`timescale 1ns/10ps

module reaction import reaction_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_tick,
    input  logic             i_start,
    input  logic             i_stop,
    input  logic             i_clear,
    output logic [VAL_W-1:0] o_display_val,
    output logic             o_display_greeting,
    output logic             o_led
);

    logic [1:0]       state;
    logic             start_q;
    logic             stop_q;
    logic             clear_q;
    logic             start_rise;
    logic             stop_rise;
    logic             clear_rise;
    logic [15:0]      lfsr;
    logic [15:0]      wait_cnt;
    logic [VAL_W-1:0] run_cnt;   // Milliseconds, or the false-start code

    // Edge detection on the debounced levels
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            start_q <= 1'b0;
            stop_q  <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            start_q <= i_start;
            stop_q  <= i_stop;
            clear_q <= i_clear;
        end
    end

    assign start_rise = i_start & ~start_q;
    assign stop_rise  = i_stop & ~stop_q;
    assign clear_rise = i_clear & ~clear_q;

    // Free-running Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            lfsr <= 16'hACE1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= S_IDLE;
            wait_cnt <= 16'd0;
            run_cnt  <= '0;
        end else if (clear_rise) begin
            state   <= S_IDLE;  // From any state
            run_cnt <= '0;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (start_rise) begin
                        state    <= S_WAIT;
                        wait_cnt <= WAIT_MIN + (lfsr & WAIT_MASK);
                        run_cnt  <= '0;
                    end
                end
                S_WAIT: begin
                    if (stop_rise) begin
                        state   <= S_DONE;
                        run_cnt <= VAL_MAX;  // False start
                    end else if (wait_cnt == 16'd0) begin
                        state   <= S_RUN;    // LEDs light here
                        run_cnt <= '0;
                    end else if (i_tick) begin
                        wait_cnt <= wait_cnt - 16'd1;
                    end
                end
                S_RUN: begin
                    if (stop_rise) begin
                        state <= S_DONE;     // Count freezes
                    end else if (i_tick && run_cnt != VAL_MAX) begin
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign o_display_val      = run_cnt;
    assign o_display_greeting = (state == S_IDLE);
    assign o_led              = (state == S_RUN);

endmodule

// File: reaction_pkg.sv
package reaction_pkg;

    // Timebase
    localparam int TICK_DIV_DEF = 100000;  // 100 MHz clock to 1 ms
    localparam int SCAN_TICKS   = 1;       // Ticks per display digit

    // Button handling
    localparam logic [7:0] DB_TICKS = 8'd10;  // Stable ticks before a change
    localparam int N_BTN     = 3;
    localparam int BTN_START = 0;
    localparam int BTN_STOP  = 1;
    localparam int BTN_CLEAR = 2;

    // Displayed value
    localparam int VAL_W = 14;
    localparam logic [VAL_W-1:0] VAL_MAX = 14'd9999;  // Saturation and false start

    // Random wait before the LEDs light
    localparam logic [15:0] WAIT_MIN  = 16'd1000;
    localparam logic [15:0] WAIT_MASK = 16'h03FF;  // Up to 1023 extra ticks

    // Controller states
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_WAIT = 2'd1;
    localparam logic [1:0] S_RUN  = 2'd2;
    localparam logic [1:0] S_DONE = 2'd3;

endpackage

// File: reaction_properties.sv
`timescale 1ns/10ps

module reaction_properties (
    input logic       i_clk,
    input logic       i_rst,
    input logic [7:0] i_led,
    input logic [7:0] i_sseg_n,
    input logic [3:0] i_ldsel_n
);

    // All eight LEDs move together
    led_all_or_none: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_led == 8'h00) || (i_led == 8'hFF))
        else $error("FAILED o_led: expected 00 or ff, got %h", i_led);

    // Exactly one digit enabled once the scan runs
    one_digit_selected: assert property (@(posedge i_clk) disable iff (i_rst)
        !$past(i_rst) |-> $onehot(~i_ldsel_n))
        else $error("FAILED o_ldsel_n: expected one bit low, got %h", i_ldsel_n);

    dp_dark: assert property (@(posedge i_clk) disable iff (i_rst) i_sseg_n[7])
        else $error("FAILED o_sseg_n: expected bit 7 high, got %h", i_sseg_n);

endmodule

// File: reaction_top.sv
`timescale 1ns/10ps

module reaction_top import reaction_pkg::*; #(
    parameter int TICK_DIV = TICK_DIV_DEF
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic [N_BTN-1:0] i_btn,
    output logic [7:0]       o_led,
    output logic [7:0]       o_sseg_n,
    output logic [3:0]       o_ldsel_n
);

    logic             w_tick;
    logic [N_BTN-1:0] w_btn_db;
    logic [VAL_W-1:0] w_display_val;
    logic             w_display_greeting;
    logic             w_led;

    tick_gen #(.P_DIV(TICK_DIV)) u_tick_gen (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .o_tick (w_tick)
    );

    for (genvar k = 0; k < N_BTN; k++) begin : g_db
        debouncer u_debouncer (
            .i_clk          (i_clk),
            .i_rst          (i_rst),
            .i_tick         (w_tick),
            .i_sw           (i_btn[k]),
            .o_sw_debounced (w_btn_db[k])
        );
    end

    reaction u_reaction (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_tick             (w_tick),
        .i_start            (w_btn_db[BTN_START]),
        .i_stop             (w_btn_db[BTN_STOP]),
        .i_clear            (w_btn_db[BTN_CLEAR]),
        .o_display_val      (w_display_val),
        .o_display_greeting (w_display_greeting),
        .o_led              (w_led)
    );

    sseg4 u_sseg4 (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_tick     (w_tick),
        .i_bin      (w_display_val),
        .i_greeting (w_display_greeting),  // Shows "HI" when high
        .o_sseg_n   (o_sseg_n),
        .o_ldsel_n  (o_ldsel_n)
    );

    assign o_led = {8{w_led}};  // One stimulus, all eight LEDs

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_reaction -o tb_reaction_sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_reaction_sim > sim.log 2>&1
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: sseg4.sv
`timescale 1ns/10ps

module sseg4 import reaction_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_tick,
    input  logic [VAL_W-1:0] i_bin,
    input  logic             i_greeting,
    output logic [7:0]       o_sseg_n,   // {dp, g, f, e, d, c, b, a}
    output logic [3:0]       o_ldsel_n   // Bit 0 is the right-hand digit
);

    logic [VAL_W-1:0] bin_clamped;
    logic             conv_start;
    logic             conv_done;
    logic             conv_busy;
    logic [15:0]      conv_bcd;
    logic [15:0]      bcd_q;
    logic [7:0]       scan_cnt;
    logic [1:0]       dig_idx;
    logic [3:0]       cur_digit;
    logic [6:0]       seg;       // Active high, {g .. a}

    function automatic logic [6:0] dec7(input logic [3:0] d);
        case (d)
            4'd0:    return 7'h3F;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5B;
            4'd3:    return 7'h4F;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6D;
            4'd6:    return 7'h7D;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7F;
            4'd9:    return 7'h6F;
            default: return 7'h00;
        endcase
    endfunction

    // Anything above four digits shows as 9999
    assign bin_clamped = (i_bin > VAL_MAX) ? VAL_MAX : i_bin;
    assign conv_start  = ~conv_busy;  // Convert back to back

    bin2bcd u_bin2bcd (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (conv_start),
        .i_bin   (bin_clamped),
        .o_bcd   (conv_bcd),
        .o_done  (conv_done),
        .o_busy  (conv_busy)
    );

    always_ff @(posedge i_clk) begin
        if (conv_done) begin
            bcd_q <= conv_bcd;
        end
    end

    // Digit scan
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            scan_cnt <= 8'd0;
            dig_idx  <= 2'd0;
        end else if (i_tick) begin
            if (scan_cnt == 8'(SCAN_TICKS - 1)) begin
                scan_cnt <= 8'd0;
                dig_idx  <= dig_idx + 2'd1;
            end else begin
                scan_cnt <= scan_cnt + 8'd1;
            end
        end
    end

    assign cur_digit = bcd_q[4*dig_idx +: 4];

    always_comb begin
        if (i_greeting) begin
            case (dig_idx)
                2'd0:    seg = 7'h30;  // "I" on segments e and f
                2'd1:    seg = 7'h76;  // "H"
                default: seg = 7'h00;
            endcase
        end else begin
            seg = dec7(cur_digit);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_sseg_n  <= 8'hFF;  // All dark
            o_ldsel_n <= 4'hF;
        end else begin
            o_sseg_n  <= {1'b1, ~seg};  // Decimal point off
            o_ldsel_n <= ~(4'b0001 << dig_idx);
        end
    end

endmodule

// File: tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #10 o_clk = ~o_clk;  // 20 ns period
        end
    end

endmodule

// File: tb_reaction.sv
`timescale 1ns/10ps

module tb_reaction import reaction_pkg::*; ();

    localparam int TB_TICK_DIV = 10;  // Short milliseconds
    localparam int RISE_MIN = int'(WAIT_MIN) * TB_TICK_DIV;
    localparam int RISE_MAX = (int'(WAIT_MIN) + 1023 + int'(DB_TICKS) + 3) * TB_TICK_DIV;
    localparam logic [N_BTN-1:0] PUSH_START = N_BTN'(1 << BTN_START);
    localparam logic [N_BTN-1:0] PUSH_STOP  = N_BTN'(1 << BTN_STOP);
    localparam logic [N_BTN-1:0] PUSH_CLEAR = N_BTN'(1 << BTN_CLEAR);
    localparam logic [4:0]  SYM_H     = 5'd16;
    localparam logic [4:0]  SYM_I     = 5'd17;
    localparam logic [4:0]  SYM_BLANK = 5'd18;
    localparam logic [19:0] SHOW_HI   = {SYM_BLANK, SYM_BLANK, SYM_H, SYM_I};
    localparam logic [19:0] SHOW_9999 = {4{5'd9}};

    logic             clk;
    logic             rst;
    logic [N_BTN-1:0] btn;
    logic [7:0]       led;
    logic [7:0]       sseg_n;
    logic [3:0]       ldsel_n;
    logic             led_count_clr;
    int               led_clocks;

    tb_clock u_clock (.o_clk(clk));

    reaction_top #(.TICK_DIV(TB_TICK_DIV)) i_reaction_top (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_btn     (btn),
        .o_led     (led),
        .o_sseg_n  (sseg_n),
        .o_ldsel_n (ldsel_n)
    );

    bind reaction_top reaction_properties u_properties (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_led     (o_led),
        .i_sseg_n  (o_sseg_n),
        .i_ldsel_n (o_ldsel_n)
    );

    // Clocks with the LEDs lit, sampled mid-cycle
    always @(negedge clk) begin
        if (led_count_clr) led_clocks <= 0;
        else if (led != 8'h00) led_clocks <= led_clocks + 1;
    end

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Segments lit high in gfedcba order
    function automatic logic [4:0] segments_to_symbol(input logic [7:0] seg_n);
        case (~seg_n[6:0])
            7'b0111111: return 5'd0;
            7'b0000110: return 5'd1;
            7'b1011011: return 5'd2;
            7'b1001111: return 5'd3;
            7'b1100110: return 5'd4;
            7'b1101101: return 5'd5;
            7'b1111101: return 5'd6;
            7'b0000111: return 5'd7;
            7'b1111111: return 5'd8;
            7'b1101111: return 5'd9;
            7'b1110110: return SYM_H;
            7'b0110000: return SYM_I;
            7'b0000000: return SYM_BLANK;
            default:    return 5'd31;  // Not a known glyph
        endcase
    endfunction

    function automatic int symbols_to_number(input logic [19:0] s);
        if (s[19:15] > 5'd9 || s[14:10] > 5'd9 || s[9:5] > 5'd9 || s[4:0] > 5'd9) return -1;
        return int'(s[19:15]) * 1000 + int'(s[14:10]) * 100
            + int'(s[9:5]) * 10 + int'(s[4:0]);
    endfunction

    // Collects one full scan, left-hand digit in the top bits
    task automatic read_display(output logic [19:0] shown);
        logic [4:0] dig [4];
        logic [3:0] seen;
        logic [1:0] idx;
        int         n;
        seen = 4'h0;
        n = 0;
        while (seen != 4'hF && n < 100) begin
            @(negedge clk);
            n++;
            case (ldsel_n)
                4'b1110: idx = 2'd0;
                4'b1101: idx = 2'd1;
                4'b1011: idx = 2'd2;
                default: idx = 2'd3;
            endcase
            if (ldsel_n != 4'hF) begin
                dig[idx]  = segments_to_symbol(sseg_n);
                seen[idx] = 1'b1;
            end
        end
        if (seen != 4'hF) fail_with("Timed out waiting for all four digits to be scanned");
        shown = {dig[3], dig[2], dig[1], dig[0]};
    endtask

    // A negative exp_num compares glyphs, otherwise the number within one
    task automatic check_display(input logic [19:0] exp_sym, input int exp_num,
                                 input string what);
        logic [19:0] shown;
        logic        ok;
        int          got;
        int          tries;
        tries = 0;
        do begin
            read_display(shown);
            got = symbols_to_number(shown);
            if (exp_num < 0) ok = (shown == exp_sym);
            else ok = (got >= 0) && (got >= exp_num - 1) && (got <= exp_num + 1);
            tries++;
        end while (!ok && tries < 20);
        assert (ok) else begin
            if (exp_num < 0) fail_with($sformatf("FAILED o_sseg_n (%s): expected %h got %h",
                                                 what, exp_sym, shown));
            else fail_with($sformatf("FAILED o_sseg_n (%s): expected %h within 1, got %h",
                                     what, exp_num, got));
        end
    endtask

    task automatic press_button(input logic [N_BTN-1:0] push, output int spent);
        int hold_hi;
        int hold_lo;
        hold_hi = 130 + int'($urandom % 60);  // Well past the debounce time
        hold_lo = 130 + int'($urandom % 60);
        @(posedge clk);
        btn <= push;
        repeat (hold_hi) @(posedge clk);
        btn <= '0;
        repeat (hold_lo) @(posedge clk);
        spent = hold_hi + hold_lo;
    endtask

    task automatic wait_led(input logic level, input int limit, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (led[0] != level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (led[0] != level) fail_with($sformatf("Timed out waiting for the LEDs to turn %s",
                                                 level ? "on" : "off"));
    endtask

    task automatic clear_led_count();
        @(posedge clk);
        led_count_clr <= 1'b1;
        @(posedge clk);
        led_count_clr <= 1'b0;
    endtask

    initial begin
        int spent;
        int waited;
        int expected_ms;
        rst = 1'b1;
        btn = '0;
        led_count_clr = 1'b0;
        void'($urandom(32'h38d5));
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        check_display(SHOW_HI, -1, "after reset");
        assert (led == 8'h00) else fail_with($sformatf("FAILED o_led: expected %h got %h",
                                                       8'h00, led));

        // Full round with a measured reaction
        clear_led_count();
        press_button(PUSH_START, spent);
        wait_led(1'b1, RISE_MAX + 1000, waited);
        assert (spent + waited >= RISE_MIN && spent + waited <= RISE_MAX) else
            fail_with($sformatf("FAILED o_led rise delay: expected %h to %h clocks, got %h",
                                RISE_MIN, RISE_MAX, spent + waited));
        repeat (200 + int'($urandom % 400)) @(posedge clk);  // Player reaction
        press_button(PUSH_STOP, spent);
        wait_led(1'b0, 1000, waited);
        @(posedge clk);
        expected_ms = led_clocks / TB_TICK_DIV;
        check_display('0, expected_ms, "measured time");

        press_button(PUSH_CLEAR, spent);
        check_display(SHOW_HI, -1, "clear after a result");

        // False start, LEDs must stay dark past the longest wait
        press_button(PUSH_START, spent);
        repeat (100 + int'($urandom % 200)) @(posedge clk);
        press_button(PUSH_STOP, spent);
        for (int n = 0; n < RISE_MAX; n++) begin
            @(negedge clk);
            assert (led == 8'h00) else fail_with($sformatf("FAILED o_led: expected %h got %h",
                                                           8'h00, led));
        end
        check_display(SHOW_9999, -1, "false start");

        // CLEAR while lit
        press_button(PUSH_START, spent);
        wait_led(1'b1, RISE_MAX + 1000, waited);
        repeat (50 + int'($urandom % 100)) @(posedge clk);
        press_button(PUSH_CLEAR, spent);
        wait_led(1'b0, 1000, waited);
        check_display(SHOW_HI, -1, "clear during a run");

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: tick_gen.sv
`timescale 1ns/10ps

module tick_gen import reaction_pkg::*; #(
    parameter int P_DIV = TICK_DIV_DEF  // Must be at least 2
) (
    input  logic i_clk,
    input  logic i_rst,
    output logic o_tick
);

    logic [$clog2(P_DIV)-1:0] cnt;

    // Wrap at P_DIV-1 and pulse once per wrap
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (cnt == ($clog2(P_DIV))'(P_DIV - 1)) begin
            cnt    <= '0;
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule
